/* design/isa_pkg.sv */
package isa_pkg;

    // R-type field view, also the source of rd/rs1/rs2 for every format
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    // I-type field view with the 12-bit immediate in one piece
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } instr_word_u;

    // RV32I base opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // Immediate layout of an instruction
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } imm_fmt_e;

endpackage

/* design/pipe_pkg.sv */
package pipe_pkg;

    localparam int XLEN = 32;

    // One queued fetch word with its own PC
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        isa_pkg::instr_word_u instr;
    } buf_entry_t;

    // Decode result handed to the backend
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [6:0]        opcode;
        isa_pkg::imm_fmt_e fmt;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        // Sign-extended, already shifted for B/U/J
        logic [XLEN-1:0]   imm;
        logic              illegal;
    } decoded_instr_t;

endpackage

/* design/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int          IF_WIDTH = 2,
    parameter logic [31:0] RESET_PC = 32'h0000_1000
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic [31:0]           redirect_pc_i,
    input  isa_pkg::instr_word_u  imem_rdata_i [IF_WIDTH],
    output logic                  imem_req_o,
    output logic [31:0]           imem_addr_o,
    output pipe_pkg::buf_entry_t  fetch_o [IF_WIDTH]
);
    import pipe_pkg::*;

    // Bytes covered by one fetch block
    localparam logic [XLEN-1:0] BLOCK_BYTES = XLEN'(IF_WIDTH * 4);

    logic [XLEN-1:0] pc;

    // Redirect wins over the normal block step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (flush_i) begin
            pc <= redirect_pc_i;
        end else if (!stall_i) begin
            pc <= pc + BLOCK_BYTES;
        end
    end

    assign imem_req_o  = !stall_i;
    assign imem_addr_o = pc;

    // Tag returned words, dropped while a flush is in flight
    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            fetch_o[i].valid = imem_req_o && !flush_i;
            fetch_o[i].pc    = pc + XLEN'(i * 4);
            fetch_o[i].instr = imem_rdata_i[i];
        end
    end

endmodule

/* design/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer #(
    parameter int IF_WIDTH    = 2,
    parameter int ID_WIDTH    = 2,
    parameter int BUFFER_SIZE = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pipe_pkg::buf_entry_t write_i [IF_WIDTH],
    input  logic                 accept_i [ID_WIDTH],
    input  logic                 flush_i,
    output logic                 stall_o,
    output pipe_pkg::buf_entry_t head_o [ID_WIDTH]
);
    import pipe_pkg::*;

    localparam int PTR_W = $clog2(BUFFER_SIZE);
    localparam int CNT_W = PTR_W + 1;

    buf_entry_t queue [BUFFER_SIZE];

    logic [PTR_W-1:0] read_ptr;
    logic [PTR_W-1:0] write_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] write_num;
    logic [CNT_W-1:0] accept_num;
    logic [PTR_W-1:0] wr_idx [IF_WIDTH];
    logic [PTR_W-1:0] rd_idx [ID_WIDTH];

    // Number of incoming fetch words
    always_comb begin
        write_num = '0;
        for (int i = 0; i < IF_WIDTH; i++) begin
            write_num = write_num + CNT_W'(write_i[i].valid);
        end
    end

    // Number of entries retired by the backend
    always_comb begin
        accept_num = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            accept_num = accept_num + CNT_W'(accept_i[i]);
        end
    end

    // Slot addresses wrap around the queue
    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            wr_idx[i] = write_ptr + PTR_W'(i);
        end
        for (int i = 0; i < ID_WIDTH; i++) begin
            rd_idx[i] = read_ptr + PTR_W'(i);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            if (CNT_W'(i) < write_num) begin
                queue[wr_idx[i]] <= write_i[i];
            end
        end
    end

    // Flush drops everything, including this cycle's writes and accepts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_ptr  <= '0;
            write_ptr <= '0;
            count     <= '0;
        end else if (flush_i) begin
            read_ptr  <= '0;
            write_ptr <= '0;
            count     <= '0;
        end else begin
            read_ptr  <= read_ptr + accept_num[PTR_W-1:0];
            write_ptr <= write_ptr + write_num[PTR_W-1:0];
            count     <= count + write_num - accept_num;
        end
    end

    // Stall until a whole block fits
    assign free_cnt = CNT_W'(BUFFER_SIZE) - count;
    assign stall_o  = free_cnt < CNT_W'(IF_WIDTH);

    // Oldest entries first, valid only inside the occupancy
    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            head_o[i]       = queue[rd_idx[i]];
            head_o[i].valid = CNT_W'(i) < count;
        end
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage #(
    parameter int ID_WIDTH = 2
) (
    input  pipe_pkg::buf_entry_t     entry_i   [ID_WIDTH],
    output pipe_pkg::decoded_instr_t decoded_o [ID_WIDTH]
);
    import isa_pkg::*;
    import pipe_pkg::*;

    function automatic decoded_instr_t decode_one(buf_entry_t e);
        decoded_instr_t  d;
        instr_word_u     w;
        logic [XLEN-1:0] raw;
        logic [XLEN-1:0] imm_i;
        logic [2:0]      f3;
        w     = e.instr;
        raw   = w;
        f3    = w.r.funct3;
        imm_i = {{20{w.i.imm12[11]}}, w.i.imm12};

        d.valid   = e.valid;
        d.pc      = e.pc;
        d.opcode  = w.r.opcode;
        d.fmt     = FMT_R;
        d.rd      = w.r.rd;
        d.rs1     = w.r.rs1;
        d.rs2     = w.r.rs2;
        d.imm     = '0;
        d.illegal = 1'b0;

        case (w.r.opcode)
            OP_LUI, OP_AUIPC: begin
                d.fmt = FMT_U;
                d.rs1 = '0;
                d.rs2 = '0;
                d.imm = {raw[31:12], 12'b0};
            end
            OP_JAL: begin
                d.fmt = FMT_J;
                d.rs1 = '0;
                d.rs2 = '0;
                d.imm = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
            end
            OP_JALR: begin
                d.fmt     = FMT_I;
                d.rs2     = '0;
                d.imm     = imm_i;
                d.illegal = f3 != 3'b000;
            end
            OP_BRANCH: begin
                d.fmt     = FMT_B;
                d.rd      = '0;
                d.imm     = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
                // funct3 2 and 3 are unused
                d.illegal = (f3 == 3'b010) || (f3 == 3'b011);
            end
            OP_LOAD: begin
                d.fmt     = FMT_I;
                d.rs2     = '0;
                d.imm     = imm_i;
                d.illegal = (f3 == 3'b011) || (f3 == 3'b110) || (f3 == 3'b111);
            end
            OP_STORE: begin
                d.fmt     = FMT_S;
                d.rd      = '0;
                d.imm     = {{20{w.r.funct7[6]}}, w.r.funct7, w.r.rd};
                d.illegal = f3 > 3'b010;
            end
            OP_IMM: begin
                d.fmt = FMT_I;
                d.rs2 = '0;
                d.imm = imm_i;
            end
            OP_REG: begin
                d.fmt = FMT_R;
            end
            OP_SYSTEM: begin
                d.fmt     = FMT_I;
                d.rs2     = '0;
                d.imm     = imm_i;
                d.illegal = f3 == 3'b100;
            end
            default: begin
                d.illegal = 1'b1;
            end
        endcase
        return d;
    endfunction

    // Each slot decodes independently
    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            decoded_o[i] = decode_one(entry_i[i]);
        end
    end

endmodule

/* design/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top #(
    parameter int          IF_WIDTH    = 2,
    parameter int          ID_WIDTH    = 2,
    parameter int          BUFFER_SIZE = 8,
    parameter logic [31:0] RESET_PC    = 32'h0000_1000
) (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     imem_req_o,
    output logic [31:0]              imem_addr_o,
    input  isa_pkg::instr_word_u     imem_rdata_i [IF_WIDTH],
    input  logic                     accept_i     [ID_WIDTH],
    input  logic                     flush_i,
    input  logic [31:0]              redirect_pc_i,
    output pipe_pkg::decoded_instr_t decoded_o    [ID_WIDTH]
);
    import pipe_pkg::*;

    buf_entry_t fetch_entries [IF_WIDTH];
    buf_entry_t head_entries  [ID_WIDTH];
    logic       buf_stall;

    fetch_unit #(
        .IF_WIDTH (IF_WIDTH),
        .RESET_PC (RESET_PC)
    ) fetch_unit_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_i       (buf_stall),
        .flush_i       (flush_i),
        .redirect_pc_i (redirect_pc_i),
        .imem_rdata_i  (imem_rdata_i),
        .imem_req_o    (imem_req_o),
        .imem_addr_o   (imem_addr_o),
        .fetch_o       (fetch_entries)
    );

    instr_buffer #(
        .IF_WIDTH    (IF_WIDTH),
        .ID_WIDTH    (ID_WIDTH),
        .BUFFER_SIZE (BUFFER_SIZE)
    ) instr_buffer_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .write_i  (fetch_entries),
        .accept_i (accept_i),
        .flush_i  (flush_i),
        .stall_o  (buf_stall),
        .head_o   (head_entries)
    );

    decode_stage #(
        .ID_WIDTH (ID_WIDTH)
    ) decode_stage_inst (
        .entry_i   (head_entries),
        .decoded_o (decoded_o)
    );

endmodule

/* sim/frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int          IF_WIDTH    = 2;
    localparam int          ID_WIDTH    = 2;
    localparam int          BUFFER_SIZE = 8;
    localparam logic [31:0] RESET_PC    = 32'h0000_1000;
    localparam int          CLK_PERIOD  = 20;
    localparam int          STALL_LIMIT = BUFFER_SIZE / IF_WIDTH + 1;

    // Cycle budgets per test
    localparam int STREAM_BUDGET   = 40;
    localparam int BP_BUDGET       = 50;
    localparam int PARTIAL_BUDGET  = 50;
    localparam int FLUSH_BUDGET    = 30;
    localparam int FORMAT_BUDGET   = 20;
    localparam int RANDOM_CYCLES   = 200;
    localparam int WATCHDOG_CYCLES = STREAM_BUDGET + BP_BUDGET + PARTIAL_BUDGET
                                   + FLUSH_BUDGET + FORMAT_BUDGET + RANDOM_CYCLES + 100;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           imem_req;
    logic [31:0]    imem_addr;
    instr_word_u    imem_rdata [IF_WIDTH];
    logic           accept     [ID_WIDTH];
    logic           flush;
    logic [31:0]    redirect_pc;
    decoded_instr_t decoded    [ID_WIDTH];

    // Scoreboard state
    logic [31:0] exp_pc;
    logic [7:0]  seen_idx;
    int          received;
    logic [31:0] lfsr_state = 32'h1e60b7f4;

    frontend_top frontend_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_req_o    (imem_req),
        .imem_addr_o   (imem_addr),
        .imem_rdata_i  (imem_rdata),
        .accept_i      (accept),
        .flush_i       (flush),
        .redirect_pc_i (redirect_pc),
        .decoded_o     (decoded)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Table of encodings with rd folded from the whole address
    function automatic logic [31:0] mem_word(logic [31:0] addr);
        logic [31:0] base;
        logic [4:0]  rd;
        case (addr[4:2])
            3'd0:    base = 32'hFFB1_8013;  // addi, negative imm
            3'd1:    base = 32'h0062_8033;
            3'd2:    base = 32'hFE71_2023;  // sw, low imm bits come from rd slot
            3'd3:    base = 32'hAA20_9063;
            3'd4:    base = 32'hABCD_E037;
            3'd5:    base = 32'h8012_306F;
            3'd6:    base = 32'h1235_2003;
            default: base = 32'h1234_507F;  // unknown opcode
        endcase
        rd = addr[6:2] ^ addr[11:7] ^ addr[16:12] ^ addr[21:17] ^ addr[26:22]
           ^ addr[31:27] ^ {3'b000, addr[1:0]};
        return base | {20'b0, rd, 7'b0};
    endfunction

    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            imem_rdata[i] = mem_word(imem_addr + 32'(4 * i));
        end
    end

    // Reference decode of the word stored at pc
    function automatic decoded_instr_t expected_at(logic [31:0] pc);
        decoded_instr_t d;
        logic [31:0]    w;
        logic [7:0]     legal_f3;
        w          = mem_word(pc);
        d.valid    = 1'b1;
        d.pc       = pc;
        d.opcode   = w[6:0];
        d.rd       = w[11:7];
        d.rs1      = w[19:15];
        d.rs2      = w[24:20];
        d.imm      = '0;
        d.fmt      = FMT_R;
        legal_f3   = 8'hFF;
        case (w[6:0])
            OP_LUI, OP_AUIPC: d.fmt = FMT_U;
            OP_JAL:           d.fmt = FMT_J;
            OP_JALR: begin
                d.fmt    = FMT_I;
                legal_f3 = 8'b0000_0001;
            end
            OP_BRANCH: begin
                d.fmt    = FMT_B;
                legal_f3 = 8'b1111_0011;
            end
            OP_LOAD: begin
                d.fmt    = FMT_I;
                legal_f3 = 8'b0011_0111;
            end
            OP_STORE: begin
                d.fmt    = FMT_S;
                legal_f3 = 8'b0000_0111;
            end
            OP_IMM: d.fmt = FMT_I;
            OP_REG: d.fmt = FMT_R;
            OP_SYSTEM: begin
                d.fmt    = FMT_I;
                legal_f3 = 8'b1110_1111;
            end
            default: legal_f3 = 8'h00;
        endcase
        case (d.fmt)
            FMT_I: begin
                d.rs2 = '0;
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            FMT_S: begin
                d.rd  = '0;
                d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            FMT_B: begin
                d.rd  = '0;
                d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            FMT_U: begin
                d.rs1 = '0;
                d.rs2 = '0;
                d.imm = {w[31:12], 12'b0};
            end
            FMT_J: begin
                d.rs1 = '0;
                d.rs2 = '0;
                d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: d.imm = '0;
        endcase
        d.illegal = !legal_f3[w[14:12]];
        return d;
    endfunction

    // Galois LFSR, one bit per call
    function automatic logic next_rand_bit();
        logic lsb;
        lsb        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    task automatic stop_failed();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic fail_with(string what);
        $display("ERROR: %s", what);
        stop_failed();
    endtask

    task automatic check_decoded(string name, decoded_instr_t exp, decoded_instr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_addr(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h actual %h", name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b actual %b", name, exp, act);
            stop_failed();
        end
    endtask

    // Check valid slots, accept up to take of them, move one clock on
    task automatic advance_cycle(string name, int take);
        int   n;
        logic gap;
        n   = 0;
        gap = 1'b0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (!decoded[i].valid) begin
                gap = 1'b1;
            end else if (gap) begin
                fail_with({name, ": valid decode slot behind an empty one"});
            end else begin
                check_decoded(name, expected_at(exp_pc + 32'(4 * i)), decoded[i]);
                if (i < take) begin
                    n++;
                end
            end
        end
        for (int i = 0; i < ID_WIDTH; i++) begin
            accept[i] = i < n;
        end
        for (int i = 0; i < n; i++) begin
            seen_idx[exp_pc[4:2]] = 1'b1;
            exp_pc                = exp_pc + 32'd4;
        end
        received = received + n;
        @(posedge clk);
        #2;
        for (int i = 0; i < ID_WIDTH; i++) begin
            accept[i] = 1'b0;
        end
    endtask

    task automatic collect(string name, int want, int budget);
        int start;
        int cycles;
        start  = received;
        cycles = 0;
        while (received - start < want) begin
            if (cycles == budget) begin
                fail_with({name, ": instructions stopped arriving"});
            end
            advance_cycle(name, ID_WIDTH);
            cycles++;
        end
    endtask

    task automatic test_stream();
        check_bit("test_stream", 1'b1, imem_req);
        check_addr("test_stream", RESET_PC, imem_addr);
        for (int i = 0; i < ID_WIDTH; i++) begin
            check_bit("test_stream", 1'b0, decoded[i].valid);
        end
        collect("test_stream", 24, STREAM_BUDGET);
    endtask

    task automatic test_backpressure();
        int          cycles;
        logic [31:0] held;
        cycles = 0;
        while (imem_req === 1'b1) begin
            if (cycles == STALL_LIMIT) begin
                fail_with("test_backpressure: fetch request never dropped");
            end
            advance_cycle("test_backpressure", 0);
            cycles++;
        end
        // Full buffer, so the fetch PC sits one buffer past the oldest entry
        held = exp_pc + 32'(4 * BUFFER_SIZE);
        check_addr("test_backpressure", held, imem_addr);
        repeat (4) begin
            advance_cycle("test_backpressure", 0);
            check_bit("test_backpressure", 1'b0, imem_req);
            check_addr("test_backpressure", held, imem_addr);
        end
        // Freeing one block must restart fetch at the held address
        advance_cycle("test_backpressure", ID_WIDTH);
        check_bit("test_backpressure", 1'b1, imem_req);
        check_addr("test_backpressure", held, imem_addr);
        collect("test_backpressure", 12, BP_BUDGET - 12);
    endtask

    task automatic test_partial_accept();
        int waited;
        repeat (4) begin
            waited = 0;
            while (decoded[1].valid !== 1'b1) begin
                if (waited == PARTIAL_BUDGET / 4) begin
                    fail_with("test_partial_accept: slot 1 never became valid");
                end
                advance_cycle("test_partial_accept", 0);
                waited++;
            end
            advance_cycle("test_partial_accept", 1);
            // Old slot 1 moves up to slot 0
            check_decoded("test_partial_accept", expected_at(exp_pc), decoded[0]);
        end
    endtask

    task automatic test_flush();
        logic [31:0] target;
        target      = 32'h0000_2040;
        flush       = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #2;
        flush = 1'b0;
        check_addr("test_flush", target, imem_addr);
        for (int i = 0; i < ID_WIDTH; i++) begin
            check_bit("test_flush", 1'b0, decoded[i].valid);
        end
        exp_pc = target;
        collect("test_flush", 12, FLUSH_BUDGET);
    endtask

    task automatic test_decode_formats();
        int cycles;
        cycles   = 0;
        seen_idx = '0;
        while (seen_idx != 8'hFF) begin
            if (cycles == FORMAT_BUDGET) begin
                fail_with("test_decode_formats: encoding table not covered");
            end
            for (int i = 0; i < ID_WIDTH; i++) begin
                if (decoded[i].valid && decoded[i].pc[4:2] == 3'd7) begin
                    check_bit("test_decode_formats", 1'b1, decoded[i].illegal);
                end
            end
            advance_cycle("test_decode_formats", ID_WIDTH);
            cycles++;
        end
    endtask

    task automatic test_random_accept();
        int   start;
        int   take;
        logic bit_val;
        start = received;
        repeat (RANDOM_CYCLES) begin
            take = 0;
            for (int i = 0; i < ID_WIDTH; i++) begin
                bit_val = next_rand_bit();
                if (bit_val && take == i) begin
                    take++;
                end
            end
            advance_cycle("test_random_accept", take);
        end
        if (received == start) begin
            fail_with("test_random_accept: no instruction was delivered");
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        redirect_pc = '0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            accept[i] = 1'b0;
        end
        exp_pc   = RESET_PC;
        seen_idx = '0;
        received = 0;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_stream();
        test_backpressure();
        test_partial_accept();
        test_flush();
        test_decode_formats();
        test_random_accept();
        $display("All tests passed");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_with("simulation timed out");
    end

endmodule

/* src.f */
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_unit.sv
design/instr_buffer.sv
design/decode_stage.sv
design/frontend_top.sv
sim/frontend_tb.sv

/* Bender.yml */
package:
  name: rv32i_frontend

sources:
  - files:
      - design/isa_pkg.sv
      - design/pipe_pkg.sv
      - design/fetch_unit.sv
      - design/instr_buffer.sv
      - design/decode_stage.sv
      - design/frontend_top.sv
  - target: simulation
    files:
      - sim/frontend_tb.sv
